/* sources.f */
+incdir+test
design/mem_map_pkg.sv
design/region_decoder.sv
design/slave_port_mux.sv
design/read_return_mux.sv
design/mem_router.sv
test/tb_mem_router.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_mem_router
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* test/router_model.svh */
`ifndef ROUTER_MODEL_SVH
`define ROUTER_MODEL_SVH

mem_addr_u         exp_addr     [NUM_SLAVES];
logic              exp_we_n     [NUM_SLAVES];
logic              exp_re_n     [NUM_SLAVES];
logic              exp_wdata_oe [NUM_SLAVES];
logic [DATA_W-1:0] exp_wdata    [NUM_SLAVES];
logic [DATA_W-1:0] exp_cpu_rdata, exp_ppu_rdata, exp_rdma_rdata;
logic              exp_cpu_rdata_oe, exp_ppu_rdata_oe;

function automatic logic is_lcd_reg(input logic [ADDR_W/2-1:0] offset);
   return offset inside {REG_LCDC, REG_STAT, REG_SCY, REG_SCX, REG_LY, REG_LYC,
                         REG_BGP, REG_OBP0, REG_OBP1, REG_WY, REG_WX, REG_VBK,
                         REG_BCPS, REG_BCPD, REG_OCPS, REG_OCPD};
endfunction

// Walks the map upward, holes fall through with no hit.
function automatic logic [NUM_SLAVES-1:0] decode_region(input mem_addr_u a, input logic active);
   logic [NUM_SLAVES-1:0] h;
   h = '0;
   if (!active)                                   h = '0;
   else if (a.flat < CART_HI)                     h[SLV_CART] = 1'b1;
   else if (a.flat < VRAM_HI)                     h[SLV_VRAM] = 1'b1;
   else if (a.flat < EXT_HI)                      h[SLV_CART] = 1'b1;  // External RAM.
   else if (a.flat < WRAM_HI)                     h[SLV_WRAM] = 1'b1;
   else if (a.flat >= OAM_LO && a.flat < OAM_HI)  h[SLV_VRAM] = 1'b1;
   else if (a.reg_page.page == IO_PAGE && is_lcd_reg(a.reg_page.offset))
      h[SLV_VRAM] = 1'b1;
   else if (a.flat >= IOREG_LO && a.flat < IOREG_HI)
      h[SLV_IOREG] = 1'b1;
   return h;
endfunction

function automatic logic [DATA_W-1:0] read_back(input logic [NUM_SLAVES-1:0] h,
                                                input logic re_n);
   logic [DATA_W-1:0] d;
   d = '0;
   for (int s = 0; s < NUM_SLAVES; s++) begin
      if (!re_n && h[s]) d = slv_rdata[s];
   end
   return d;
endfunction

task automatic update_model();
   logic [NUM_SLAVES-1:0] cpu_h;
   logic [NUM_SLAVES-1:0] ppu_h;
   logic [NUM_SLAVES-1:0] rdma_h;
   logic [NUM_SLAVES-1:0] wdma_h;
   cpu_h  = decode_region(cpu_addr, !cpu_we_n || !cpu_re_n);
   ppu_h  = decode_region(ppu_addr, !ppu_we_n || !ppu_re_n);
   rdma_h = decode_region(rdma_addr, !rdma_re_n);
   wdma_h = decode_region(wdma_addr, !wdma_we_n);
   for (int s = 0; s < NUM_SLAVES; s++) begin
      exp_we_n[s]  = 1'b1;
      exp_wdata[s] = '0;
      exp_re_n[s]  = 1'b1;
      exp_addr[s]  = '0;
      if (cpu_h[s]) begin
         exp_we_n[s]  = cpu_we_n;
         exp_wdata[s] = cpu_wdata;
         exp_re_n[s]  = cpu_re_n;
         exp_addr[s]  = cpu_addr;
      end else if (ppu_h[s]) begin
         exp_we_n[s]  = ppu_we_n;
         exp_wdata[s] = ppu_wdata;
         exp_re_n[s]  = ppu_re_n;
         exp_addr[s]  = ppu_addr;
      end else begin
         if (wdma_h[s]) begin
            exp_we_n[s]  = wdma_we_n;
            exp_wdata[s] = wdma_wdata;
         end
         if (rdma_h[s]) exp_re_n[s] = rdma_re_n;
         if (rdma_h[s])      exp_addr[s] = rdma_addr;
         else if (wdma_h[s]) exp_addr[s] = wdma_addr;
      end
      exp_wdata_oe[s] = !exp_we_n[s];
   end
   exp_cpu_rdata    = read_back(cpu_h, cpu_re_n);
   exp_cpu_rdata_oe = !cpu_re_n && (cpu_h != '0);
   exp_ppu_rdata    = read_back(ppu_h, ppu_re_n);
   exp_ppu_rdata_oe = !ppu_re_n && (ppu_h != '0);
   exp_rdma_rdata   = read_back(rdma_h, rdma_re_n);
endtask

`endif

/* test/tb_mem_router.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_router;

   import mem_map_pkg::*;

   localparam int RESET_CYCLES   = 16;
   localparam int IDLE_CYCLES    = 8;
   localparam int SINGLE_CYCLES  = 200;
   localparam int CONTEND_CYCLES = 100;
   localparam int MIX_CYCLES     = 4000;
   localparam int TIMEOUT_CYCLES = 5000;  // Run itself takes 4324 cycles.

   localparam int MODE_IDLE    = 0;
   localparam int MODE_SINGLE  = 1;
   localparam int MODE_CONTEND = 2;
   localparam int MODE_MIX     = 3;

   // Region edges, the start of the E000 hole and the I/O window ends.
   localparam logic [ADDR_W-1:0] EDGES [16] = '{
      CART_LO, VRAM_LO, EXT_LO, WRAM_LO, WRAM_HI, OAM_LO, OAM_HI, IOREG_LO,
      IOREG_HI, VRAM_LO, EXT_LO, WRAM_LO, OAM_LO, OAM_HI, IOREG_LO, IOREG_HI};

   logic              clk = 1'b0;
   logic              rst;
   mem_addr_u         cpu_addr, ppu_addr, rdma_addr, wdma_addr;
   logic              cpu_we_n, cpu_re_n, ppu_we_n, ppu_re_n, rdma_re_n, wdma_we_n;
   logic [DATA_W-1:0] cpu_wdata, ppu_wdata, wdma_wdata;
   logic [DATA_W-1:0] cpu_rdata, ppu_rdata, rdma_rdata;
   logic              cpu_rdata_oe, ppu_rdata_oe;
   mem_addr_u         slv_addr     [NUM_SLAVES];
   logic              slv_we_n     [NUM_SLAVES];
   logic              slv_re_n     [NUM_SLAVES];
   logic              slv_wdata_oe [NUM_SLAVES];
   logic [DATA_W-1:0] slv_wdata    [NUM_SLAVES];
   logic [DATA_W-1:0] slv_rdata    [NUM_SLAVES];
   logic [31:0]       rng_state   = 32'hc0eb;
   int                cycle_count = 0;
   string             slave_name [NUM_SLAVES] = '{"cart", "vram", "wram", "ioreg"};

   `include "router_model.svh"

   mem_router uut (
      .*,
      .cart_addr(slv_addr[SLV_CART]), .cart_we_n(slv_we_n[SLV_CART]),
      .cart_re_n(slv_re_n[SLV_CART]), .cart_wdata(slv_wdata[SLV_CART]),
      .cart_wdata_oe(slv_wdata_oe[SLV_CART]), .cart_rdata(slv_rdata[SLV_CART]),
      .vram_addr(slv_addr[SLV_VRAM]), .vram_we_n(slv_we_n[SLV_VRAM]),
      .vram_re_n(slv_re_n[SLV_VRAM]), .vram_wdata(slv_wdata[SLV_VRAM]),
      .vram_wdata_oe(slv_wdata_oe[SLV_VRAM]), .vram_rdata(slv_rdata[SLV_VRAM]),
      .wram_addr(slv_addr[SLV_WRAM]), .wram_we_n(slv_we_n[SLV_WRAM]),
      .wram_re_n(slv_re_n[SLV_WRAM]), .wram_wdata(slv_wdata[SLV_WRAM]),
      .wram_wdata_oe(slv_wdata_oe[SLV_WRAM]), .wram_rdata(slv_rdata[SLV_WRAM]),
      .ioreg_addr(slv_addr[SLV_IOREG]), .ioreg_we_n(slv_we_n[SLV_IOREG]),
      .ioreg_re_n(slv_re_n[SLV_IOREG]), .ioreg_wdata(slv_wdata[SLV_IOREG]),
      .ioreg_wdata_oe(slv_wdata_oe[SLV_IOREG]), .ioreg_rdata(slv_rdata[SLV_IOREG])
   );

   always #4 clk = ~clk;

   task automatic abort_run();
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic check_addr(input string name, input mem_addr_u exp, input mem_addr_u got);
      if (got !== exp) begin
         $display("Error at %0t: %s expected %h actual %h", $time, name, exp.flat, got.flat);
         abort_run();
      end
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] got);
      if (got !== exp) begin
         $display("Error at %0t: %s expected %h actual %h", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_strobe(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         $display("Error at %0t: %s expected %b actual %b", $time, name, exp, got);
         abort_run();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic mem_addr_u pick_addr();
      logic [31:0] r;
      mem_addr_u   a;
      r = next_rand();
      case (r[1:0])
         2'd0: a.flat = r[31:16];
         2'd1: begin
            a.reg_page.page   = IO_PAGE;  // LCD block and its neighbours.
            a.reg_page.offset = r[9] ? {3'b010, r[8:4]} : {4'b0110, r[7:4]};
         end
         default: a.flat = EDGES[r[5:2]] + {14'b0, r[7:6]} - 16'd2;
      endcase
      return a;
   endfunction

   task automatic drive_cycle(input int mode);
      logic [31:0] r;
      logic [31:0] d;
      mem_addr_u   base;
      r = next_rand();
      d = next_rand();
      {cpu_wdata, ppu_wdata, wdma_wdata} = r[23:0];
      {slv_rdata[0], slv_rdata[1], slv_rdata[2], slv_rdata[3]} = d;
      {cpu_we_n, cpu_re_n, ppu_we_n, ppu_re_n, rdma_re_n, wdma_we_n} = '1;
      r    = next_rand();
      base = pick_addr();
      case (mode)
         MODE_SINGLE: begin  // One master at a time.
            case (r[2:0])
               3'd0: begin cpu_addr = base; cpu_we_n = 1'b0; end
               3'd1: begin cpu_addr = base; cpu_re_n = 1'b0; end
               3'd2: begin ppu_addr = base; ppu_we_n = 1'b0; end
               3'd3: begin ppu_addr = base; ppu_re_n = 1'b0; end
               3'd4, 3'd5: begin rdma_addr = base; rdma_re_n = 1'b0; end
               default: begin wdma_addr = base; wdma_we_n = 1'b0; end
            endcase
         end
         MODE_CONTEND: begin  // Mostly the same slave for everyone.
            cpu_addr      = base;
            rdma_addr     = base;
            wdma_addr     = base;
            ppu_addr.flat = {base.flat[ADDR_W-1:4], r[7:4]};
            {cpu_we_n, ppu_we_n, wdma_we_n, rdma_re_n} = r[3:0];
         end
         MODE_MIX: begin
            cpu_addr  = base;
            ppu_addr  = pick_addr();
            rdma_addr = pick_addr();
            wdma_addr = pick_addr();
            cpu_re_n  = (r[1:0] != 2'd1);
            cpu_we_n  = !r[1];
            ppu_re_n  = (r[3:2] != 2'd1);
            ppu_we_n  = !r[3];
            rdma_re_n = r[4];
            wdma_we_n = r[5];
         end
         default: ;
      endcase
   endtask

   task automatic run_phase(input int mode, input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         drive_cycle(mode);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Checking and run control
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      update_model();
      for (int s = 0; s < NUM_SLAVES; s++) begin
         check_addr({slave_name[s], "_addr"}, exp_addr[s], slv_addr[s]);
         check_strobe({slave_name[s], "_we_n"}, exp_we_n[s], slv_we_n[s]);
         check_strobe({slave_name[s], "_re_n"}, exp_re_n[s], slv_re_n[s]);
         check_strobe({slave_name[s], "_wdata_oe"}, exp_wdata_oe[s], slv_wdata_oe[s]);
         check_data({slave_name[s], "_wdata"}, exp_wdata[s], slv_wdata[s]);
      end
      check_data("cpu_rdata", exp_cpu_rdata, cpu_rdata);
      check_strobe("cpu_rdata_oe", exp_cpu_rdata_oe, cpu_rdata_oe);
      check_data("ppu_rdata", exp_ppu_rdata, ppu_rdata);
      check_strobe("ppu_rdata_oe", exp_ppu_rdata_oe, ppu_rdata_oe);
      check_data("rdma_rdata", exp_rdma_rdata, rdma_rdata);
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   initial begin
      rst       = 1'b1;
      cpu_addr  = '0;
      ppu_addr  = '0;
      rdma_addr = '0;
      wdma_addr = '0;
      drive_cycle(MODE_IDLE);
      run_phase(MODE_IDLE, RESET_CYCLES);
      rst = 1'b0;
      run_phase(MODE_IDLE, IDLE_CYCLES);
      run_phase(MODE_SINGLE, SINGLE_CYCLES);
      run_phase(MODE_CONTEND, CONTEND_CYCLES);
      run_phase(MODE_MIX, MIX_CYCLES);
      @(posedge clk);
      @(negedge clk);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* design/mem_router.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_router (
   input  logic                             clk,
   input  logic                             rst,

   // Masters.
   input  mem_map_pkg::mem_addr_u           cpu_addr,
   input  logic                             cpu_we_n,
   input  logic                             cpu_re_n,
   input  logic [mem_map_pkg::DATA_W-1:0]   cpu_wdata,
   output logic [mem_map_pkg::DATA_W-1:0]   cpu_rdata,
   output logic                             cpu_rdata_oe,

   input  mem_map_pkg::mem_addr_u           ppu_addr,
   input  logic                             ppu_we_n,
   input  logic                             ppu_re_n,
   input  logic [mem_map_pkg::DATA_W-1:0]   ppu_wdata,
   output logic [mem_map_pkg::DATA_W-1:0]   ppu_rdata,
   output logic                             ppu_rdata_oe,

   input  mem_map_pkg::mem_addr_u           rdma_addr,
   input  logic                             rdma_re_n,
   output logic [mem_map_pkg::DATA_W-1:0]   rdma_rdata,

   input  mem_map_pkg::mem_addr_u           wdma_addr,
   input  logic                             wdma_we_n,
   input  logic [mem_map_pkg::DATA_W-1:0]   wdma_wdata,

   // Slaves.
   output mem_map_pkg::mem_addr_u           cart_addr,
   output logic                             cart_we_n,
   output logic                             cart_re_n,
   output logic [mem_map_pkg::DATA_W-1:0]   cart_wdata,
   output logic                             cart_wdata_oe,
   input  logic [mem_map_pkg::DATA_W-1:0]   cart_rdata,

   output mem_map_pkg::mem_addr_u           vram_addr,
   output logic                             vram_we_n,
   output logic                             vram_re_n,
   output logic [mem_map_pkg::DATA_W-1:0]   vram_wdata,
   output logic                             vram_wdata_oe,
   input  logic [mem_map_pkg::DATA_W-1:0]   vram_rdata,

   output mem_map_pkg::mem_addr_u           wram_addr,
   output logic                             wram_we_n,
   output logic                             wram_re_n,
   output logic [mem_map_pkg::DATA_W-1:0]   wram_wdata,
   output logic                             wram_wdata_oe,
   input  logic [mem_map_pkg::DATA_W-1:0]   wram_rdata,

   output mem_map_pkg::mem_addr_u           ioreg_addr,
   output logic                             ioreg_we_n,
   output logic                             ioreg_re_n,
   output logic [mem_map_pkg::DATA_W-1:0]   ioreg_wdata,
   output logic                             ioreg_wdata_oe,
   input  logic [mem_map_pkg::DATA_W-1:0]   ioreg_rdata
);

   import mem_map_pkg::*;

   logic                  cpu_active;
   logic                  ppu_active;
   logic                  rdma_active;
   logic                  wdma_active;
   logic [NUM_SLAVES-1:0] cpu_hit;
   logic [NUM_SLAVES-1:0] ppu_hit;
   logic [NUM_SLAVES-1:0] rdma_hit;
   logic [NUM_SLAVES-1:0] wdma_hit;

   ////////////////////////////////////////////////////////////
   // Address decode, one per master
   ////////////////////////////////////////////////////////////

   assign cpu_active  = !cpu_we_n || !cpu_re_n;
   assign ppu_active  = !ppu_we_n || !ppu_re_n;
   assign rdma_active = !rdma_re_n;
   assign wdma_active = !wdma_we_n;

   region_decoder u_cpu_dec  (.addr(cpu_addr),  .active(cpu_active),  .hit(cpu_hit));
   region_decoder u_ppu_dec  (.addr(ppu_addr),  .active(ppu_active),  .hit(ppu_hit));
   region_decoder u_rdma_dec (.addr(rdma_addr), .active(rdma_active), .hit(rdma_hit));
   region_decoder u_wdma_dec (.addr(wdma_addr), .active(wdma_active), .hit(wdma_hit));

   ////////////////////////////////////////////////////////////
   // Slave ports
   ////////////////////////////////////////////////////////////

   slave_port_mux u_cart_mux (
      .clk, .rst,
      .cpu_hit(cpu_hit[SLV_CART]), .ppu_hit(ppu_hit[SLV_CART]),
      .rdma_hit(rdma_hit[SLV_CART]), .wdma_hit(wdma_hit[SLV_CART]),
      .cpu_addr, .ppu_addr, .rdma_addr, .wdma_addr,
      .cpu_we_n, .cpu_re_n, .ppu_we_n, .ppu_re_n, .rdma_re_n, .wdma_we_n,
      .cpu_wdata, .ppu_wdata, .wdma_wdata,
      .addr(cart_addr), .we_n(cart_we_n), .re_n(cart_re_n),
      .wdata_oe(cart_wdata_oe), .wdata(cart_wdata)
   );

   slave_port_mux u_vram_mux (
      .clk, .rst,
      .cpu_hit(cpu_hit[SLV_VRAM]), .ppu_hit(ppu_hit[SLV_VRAM]),
      .rdma_hit(rdma_hit[SLV_VRAM]), .wdma_hit(wdma_hit[SLV_VRAM]),
      .cpu_addr, .ppu_addr, .rdma_addr, .wdma_addr,
      .cpu_we_n, .cpu_re_n, .ppu_we_n, .ppu_re_n, .rdma_re_n, .wdma_we_n,
      .cpu_wdata, .ppu_wdata, .wdma_wdata,
      .addr(vram_addr), .we_n(vram_we_n), .re_n(vram_re_n),
      .wdata_oe(vram_wdata_oe), .wdata(vram_wdata)
   );

   slave_port_mux u_wram_mux (
      .clk, .rst,
      .cpu_hit(cpu_hit[SLV_WRAM]), .ppu_hit(ppu_hit[SLV_WRAM]),
      .rdma_hit(rdma_hit[SLV_WRAM]), .wdma_hit(wdma_hit[SLV_WRAM]),
      .cpu_addr, .ppu_addr, .rdma_addr, .wdma_addr,
      .cpu_we_n, .cpu_re_n, .ppu_we_n, .ppu_re_n, .rdma_re_n, .wdma_we_n,
      .cpu_wdata, .ppu_wdata, .wdma_wdata,
      .addr(wram_addr), .we_n(wram_we_n), .re_n(wram_re_n),
      .wdata_oe(wram_wdata_oe), .wdata(wram_wdata)
   );

   slave_port_mux u_ioreg_mux (
      .clk, .rst,
      .cpu_hit(cpu_hit[SLV_IOREG]), .ppu_hit(ppu_hit[SLV_IOREG]),
      .rdma_hit(rdma_hit[SLV_IOREG]), .wdma_hit(wdma_hit[SLV_IOREG]),
      .cpu_addr, .ppu_addr, .rdma_addr, .wdma_addr,
      .cpu_we_n, .cpu_re_n, .ppu_we_n, .ppu_re_n, .rdma_re_n, .wdma_we_n,
      .cpu_wdata, .ppu_wdata, .wdma_wdata,
      .addr(ioreg_addr), .we_n(ioreg_we_n), .re_n(ioreg_re_n),
      .wdata_oe(ioreg_wdata_oe), .wdata(ioreg_wdata)
   );

   ////////////////////////////////////////////////////////////
   // Read data back to the masters
   ////////////////////////////////////////////////////////////

   read_return_mux u_cpu_ret (
      .clk, .rst, .hit(cpu_hit), .re_n(cpu_re_n),
      .cart_rdata, .vram_rdata, .wram_rdata, .ioreg_rdata,
      .rdata(cpu_rdata), .rdata_oe(cpu_rdata_oe)
   );

   read_return_mux u_ppu_ret (
      .clk, .rst, .hit(ppu_hit), .re_n(ppu_re_n),
      .cart_rdata, .vram_rdata, .wram_rdata, .ioreg_rdata,
      .rdata(ppu_rdata), .rdata_oe(ppu_rdata_oe)
   );

   // DMA read port has no enable pin.
   read_return_mux u_rdma_ret (
      .clk, .rst, .hit(rdma_hit), .re_n(rdma_re_n),
      .cart_rdata, .vram_rdata, .wram_rdata, .ioreg_rdata,
      .rdata(rdma_rdata), .rdata_oe()
   );

endmodule

`default_nettype wire

/* design/read_return_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module read_return_mux (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic [mem_map_pkg::NUM_SLAVES-1:0]   hit,
   input  logic                                 re_n,
   input  logic [mem_map_pkg::DATA_W-1:0]       cart_rdata,
   input  logic [mem_map_pkg::DATA_W-1:0]       vram_rdata,
   input  logic [mem_map_pkg::DATA_W-1:0]       wram_rdata,
   input  logic [mem_map_pkg::DATA_W-1:0]       ioreg_rdata,
   output logic [mem_map_pkg::DATA_W-1:0]       rdata,
   output logic                                 rdata_oe
);

   import mem_map_pkg::*;

   // Hit vector is one-hot or empty, so the order here does not matter.
   always_comb begin
      rdata    = '0;
      rdata_oe = 1'b0;
      if (!re_n) begin
         rdata_oe = |hit;  // Unmapped holes return nothing.
         if (hit[SLV_CART])       rdata = cart_rdata;
         else if (hit[SLV_VRAM])  rdata = vram_rdata;
         else if (hit[SLV_WRAM])  rdata = wram_rdata;
         else if (hit[SLV_IOREG]) rdata = ioreg_rdata;
      end
   end

   a_oe_only_on_read: assert property (
      @(posedge clk) disable iff (rst) rdata_oe |-> !re_n
   ) else $error("read_return_mux: read data driven outside a read");

endmodule

`default_nettype wire

/* design/slave_port_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module slave_port_mux (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               cpu_hit,
   input  logic                               ppu_hit,
   input  logic                               rdma_hit,
   input  logic                               wdma_hit,
   input  mem_map_pkg::mem_addr_u             cpu_addr,
   input  mem_map_pkg::mem_addr_u             ppu_addr,
   input  mem_map_pkg::mem_addr_u             rdma_addr,
   input  mem_map_pkg::mem_addr_u             wdma_addr,
   input  logic                               cpu_we_n,
   input  logic                               cpu_re_n,
   input  logic                               ppu_we_n,
   input  logic                               ppu_re_n,
   input  logic                               rdma_re_n,
   input  logic                               wdma_we_n,
   input  logic [mem_map_pkg::DATA_W-1:0]     cpu_wdata,
   input  logic [mem_map_pkg::DATA_W-1:0]     ppu_wdata,
   input  logic [mem_map_pkg::DATA_W-1:0]     wdma_wdata,
   output mem_map_pkg::mem_addr_u             addr,
   output logic                               we_n,
   output logic                               re_n,
   output logic                               wdata_oe,
   output logic [mem_map_pkg::DATA_W-1:0]     wdata
);

   import mem_map_pkg::*;

   ////////////////////////////////////////////////////////////
   // Fixed priority, CPU first
   ////////////////////////////////////////////////////////////

   // Write side skips the read DMA.
   always_comb begin
      we_n  = 1'b1;
      wdata = '0;
      if (cpu_hit) begin
         we_n  = cpu_we_n;
         wdata = cpu_wdata;
      end else if (ppu_hit) begin
         we_n  = ppu_we_n;
         wdata = ppu_wdata;
      end else if (wdma_hit) begin
         we_n  = wdma_we_n;
         wdata = wdma_wdata;
      end
   end

   assign wdata_oe = !we_n;  // Drive data only on a write.

   // Read side skips the write DMA.
   always_comb begin
      if (cpu_hit)       re_n = cpu_re_n;
      else if (ppu_hit)  re_n = ppu_re_n;
      else if (rdma_hit) re_n = rdma_re_n;
      else               re_n = 1'b1;
   end

   always_comb begin
      if (cpu_hit)       addr.flat = cpu_addr.flat;
      else if (ppu_hit)  addr.flat = ppu_addr.flat;
      else if (rdma_hit) addr.flat = rdma_addr.flat;
      else if (wdma_hit) addr.flat = wdma_addr.flat;
      else               addr.flat = '0;
   end

   a_oe_only_on_write: assert property (
      @(posedge clk) disable iff (rst) we_n |-> !wdata_oe
   ) else $error("slave_port_mux: write data driven without write strobe");

endmodule

`default_nettype wire

/* design/region_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module region_decoder (
   input  mem_map_pkg::mem_addr_u                addr,
   input  logic                                  active,
   output logic [mem_map_pkg::NUM_SLAVES-1:0]    hit
);

   import mem_map_pkg::*;

   logic                  in_io_page;
   logic                  lcd_offset;
   logic                  lcd_hit;
   logic [NUM_SLAVES-1:0] raw_hit;

   function automatic logic in_range(
      input logic [ADDR_W-1:0] a,
      input logic [ADDR_W-1:0] lo,
      input logic [ADDR_W-1:0] hi
   );
      return (a >= lo) && (a < hi);
   endfunction

   ////////////////////////////////////////////////////////////
   // LCD registers sit in the I/O page but belong to video RAM
   ////////////////////////////////////////////////////////////

   assign in_io_page = (addr.reg_page.page == IO_PAGE);

   always_comb begin
      case (addr.reg_page.offset)
         REG_LCDC, REG_STAT, REG_SCY, REG_SCX,
         REG_LY, REG_LYC, REG_BGP, REG_OBP0,
         REG_OBP1, REG_WY, REG_WX, REG_VBK,
         REG_BCPS, REG_BCPD, REG_OCPS, REG_OCPD: lcd_offset = 1'b1;
         default:                                lcd_offset = 1'b0;
      endcase
   end

   assign lcd_hit = in_io_page && lcd_offset;

   always_comb begin
      raw_hit            = '0;
      raw_hit[SLV_CART]  = in_range(addr.flat, CART_LO, CART_HI) ||
                           in_range(addr.flat, EXT_LO, EXT_HI);
      raw_hit[SLV_VRAM]  = in_range(addr.flat, VRAM_LO, VRAM_HI) ||
                           in_range(addr.flat, OAM_LO, OAM_HI) || lcd_hit;
      raw_hit[SLV_WRAM]  = in_range(addr.flat, WRAM_LO, WRAM_HI);
      raw_hit[SLV_IOREG] = in_range(addr.flat, IOREG_LO, IOREG_HI) && !lcd_hit;
   end

   assign hit = active ? raw_hit : '0;  // Idle master hits nothing.

   // Regions never overlap, LCD offsets are carved out of the I/O window.
   always_comb begin
      assert ($onehot0(hit))
         else $error("region_decoder: more than one slave hit");
   end

endmodule

`default_nettype wire

/* design/mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

   ////////////////////////////////////////////////////////////
   // Bus widths and slave indices
   ////////////////////////////////////////////////////////////

   localparam int ADDR_W     = 16;
   localparam int DATA_W     = 8;
   localparam int NUM_SLAVES = 4;

   localparam int SLV_CART  = 0;  // ROM and external RAM.
   localparam int SLV_VRAM  = 1;  // Tile RAM, OAM and LCD registers.
   localparam int SLV_WRAM  = 2;
   localparam int SLV_IOREG = 3;

   ////////////////////////////////////////////////////////////
   // Memory map, low bound inclusive, high bound exclusive
   ////////////////////////////////////////////////////////////

   localparam logic [ADDR_W-1:0] CART_LO  = 16'h0000;
   localparam logic [ADDR_W-1:0] CART_HI  = 16'h8000;
   localparam logic [ADDR_W-1:0] VRAM_LO  = 16'h8000;
   localparam logic [ADDR_W-1:0] VRAM_HI  = 16'ha000;
   localparam logic [ADDR_W-1:0] EXT_LO   = 16'ha000;
   localparam logic [ADDR_W-1:0] EXT_HI   = 16'hc000;
   localparam logic [ADDR_W-1:0] WRAM_LO  = 16'hc000;
   localparam logic [ADDR_W-1:0] WRAM_HI  = 16'he000;
   localparam logic [ADDR_W-1:0] OAM_LO   = 16'hfe00;
   localparam logic [ADDR_W-1:0] OAM_HI   = 16'hfea0;
   localparam logic [ADDR_W-1:0] IOREG_LO = 16'hff00;
   localparam logic [ADDR_W-1:0] IOREG_HI = 16'hff80;

   localparam logic [ADDR_W/2-1:0] IO_PAGE = 8'hff;

   ////////////////////////////////////////////////////////////
   // LCD register offsets inside the register page
   ////////////////////////////////////////////////////////////

   localparam logic [ADDR_W/2-1:0] REG_LCDC = 8'h40;
   localparam logic [ADDR_W/2-1:0] REG_STAT = 8'h41;
   localparam logic [ADDR_W/2-1:0] REG_SCY  = 8'h42;
   localparam logic [ADDR_W/2-1:0] REG_SCX  = 8'h43;
   localparam logic [ADDR_W/2-1:0] REG_LY   = 8'h44;
   localparam logic [ADDR_W/2-1:0] REG_LYC  = 8'h45;
   localparam logic [ADDR_W/2-1:0] REG_BGP  = 8'h47;
   localparam logic [ADDR_W/2-1:0] REG_OBP0 = 8'h48;
   localparam logic [ADDR_W/2-1:0] REG_OBP1 = 8'h49;
   localparam logic [ADDR_W/2-1:0] REG_WY   = 8'h4a;
   localparam logic [ADDR_W/2-1:0] REG_WX   = 8'h4b;
   localparam logic [ADDR_W/2-1:0] REG_VBK  = 8'h4f;

   // Color palette access.
   localparam logic [ADDR_W/2-1:0] REG_BCPS = 8'h68;
   localparam logic [ADDR_W/2-1:0] REG_BCPD = 8'h69;
   localparam logic [ADDR_W/2-1:0] REG_OCPS = 8'h6a;
   localparam logic [ADDR_W/2-1:0] REG_OCPD = 8'h6b;

   ////////////////////////////////////////////////////////////
   // Address word
   ////////////////////////////////////////////////////////////

   // Range compares use the flat view, register matches the split one.
   typedef union packed {
      logic [ADDR_W-1:0] flat;
      struct packed {
         logic [ADDR_W/2-1:0] page;    // High byte.
         logic [ADDR_W/2-1:0] offset;  // Low byte.
      } reg_page;
   } mem_addr_u;

endpackage

`default_nettype wire
